/* files.f */
screen_pkg.sv
key_input.sv
count_down.sv
count_down_screen.sv
screen_wb_writer.sv
screen_top.sv
screen_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= screen_tb
FILELIST ?= files.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert
PASS_MSG ?= PASS: all tests

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* screen_tb.sv */
`timescale 1ns/10ps
module screen_tb
	import screen_pkg::*;
();

	localparam int tick_div = 4; // clocks per tick
	localparam int deb_len = 3; // debounce depth in ticks
	localparam int count_start = 12; // countdown shows 0012
	localparam int settle_timeout = 4000; // clocks allowed for the display to go idle
	localparam int n_rows = 31;

	typedef struct packed {
		phase_t phase; // game phase
		game_t game; // game selector
		key_t key; // keypad value
		logic pressed; // keypad strobe
		emote_t emote_in; // emote from other board
		logic [4:0] ticks; // ticks to wait after the row
	} row_t;

	logic clk = 1'b0;
	logic rst_n = 1'b0;
	phase_t phase = phase_idle;
	game_t game = '0;
	key_t key = '0;
	logic pressed = 1'b0;
	emote_t emote_in = emote_none;
	wb_s2m_t wb_in = '0;
	emote_t emote_out;
	logic count_done;
	wb_m2s_t wb_out;

	char_t display_mem [0:15]; // slave side copy of the display
	char_t exp_chars [0:15]; // expected display line
	logic [15:0] lfsr = 16'd4613; // ack delay source
	logic busy = 1'b0; // slave holds a request
	logic [1:0] ack_wait; // cycles left before ack
	pos_t req_adr; // adr seen at request start
	char_t req_dat; // dat seen at request start

	// phase game key pressed emote_in ticks
	localparam row_t stim [0:n_rows-1] = '{
		'{phase_idle, 3'd0, 4'h0, 1'b0, 4'd8, 5'd4}, // after reset
		'{phase_idle, 3'd1, 4'h0, 1'b0, 4'd8, 5'd2}, // titles
		'{phase_idle, 3'd2, 4'h0, 1'b0, 4'd8, 5'd2},
		'{phase_idle, 3'd3, 4'h0, 1'b0, 4'd8, 5'd2},
		'{phase_idle, 3'd4, 4'h0, 1'b0, 4'd8, 5'd2},
		'{phase_idle, 3'd5, 4'h0, 1'b0, 4'd8, 5'd2},
		'{phase_idle, 3'd6, 4'h0, 1'b0, 4'd8, 5'd2}, // unknown game
		'{phase_idle, 3'd7, 4'h0, 1'b0, 4'd8, 5'd2},
		'{phase_idle, 3'd2, 4'hA, 1'b1, 4'd0, 5'd6}, // long presses
		'{phase_idle, 3'd2, 4'hA, 1'b0, 4'd1, 5'd6},
		'{phase_idle, 3'd2, 4'h2, 1'b1, 4'd2, 5'd6},
		'{phase_idle, 3'd2, 4'h2, 1'b0, 4'd3, 5'd6},
		'{phase_idle, 3'd2, 4'h5, 1'b1, 4'd4, 5'd6},
		'{phase_idle, 3'd2, 4'h5, 1'b0, 4'd5, 5'd6},
		'{phase_idle, 3'd2, 4'h8, 1'b1, 4'd6, 5'd6},
		'{phase_idle, 3'd2, 4'h8, 1'b0, 4'd7, 5'd6},
		'{phase_idle, 3'd2, 4'h0, 1'b1, 4'd8, 5'd6},
		'{phase_idle, 3'd2, 4'h0, 1'b0, 4'd15, 5'd6},
		'{phase_idle, 3'd2, 4'h1, 1'b1, 4'd0, 5'd6},
		'{phase_idle, 3'd2, 4'h1, 1'b0, 4'd8, 5'd6},
		'{phase_idle, 3'd2, 4'h4, 1'b1, 4'd1, 5'd6},
		'{phase_idle, 3'd2, 4'h4, 1'b0, 4'd8, 5'd6},
		'{phase_idle, 3'd2, 4'h7, 1'b1, 4'd2, 5'd6},
		'{phase_idle, 3'd2, 4'h7, 1'b0, 4'd8, 5'd6},
		'{phase_idle, 3'd2, 4'h3, 1'b1, 4'd8, 5'd6}, // key not in table
		'{phase_idle, 3'd2, 4'h3, 1'b0, 4'd8, 5'd6},
		'{phase_idle, 3'd2, 4'hA, 1'b1, 4'd8, 5'd1}, // short press
		'{phase_idle, 3'd2, 4'hA, 1'b0, 4'd8, 5'd6},
		'{phase_countdown, 3'd2, 4'h0, 1'b0, 4'd3, 5'd16}, // runs down to zero
		'{phase_play, 3'd2, 4'h0, 1'b0, 4'd3, 5'd4}, // held at zero
		'{phase_idle, 3'd2, 4'h0, 1'b0, 4'd8, 5'd2} // reload
	};

	screen_top #(.TICK_DIV(tick_div), .DEB_LEN(deb_len), .COUNT_START(count_start)) i_dut (
		.clk(clk), .rst_n(rst_n), .phase(phase), .game(game), .key(key),
		.pressed(pressed), .emote_in(emote_in), .wb_in(wb_in),
		.emote_out(emote_out), .count_done(count_done), .wb_out(wb_out)
	);

	always #10 clk = ~clk; // 20 ns period

	////////////////////////////////////////
	// helpers
	////////////////////////////////////////
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		lfsr_step = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1); // galois taps 16 14 13 11
	endfunction

	function automatic char_t digit_char(input int v);
		digit_char = glyph_digit_base + char_t'(v % 10); // ascii digit
	endfunction

	function automatic char_t emote_char(input emote_t e);
		emote_char = (e < 4'd8) ? 8'h80 + char_t'(e) : glyph_none; // 8 and up blank
	endfunction

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("FAIL: see errors above");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_emote(input string name, input emote_t got, input emote_t exp);
		if (got !== exp)
			stop_on_error($sformatf("Fail %s: got %h expected %h", name, got, exp));
	endtask

	task automatic check_char(input pos_t pos, input char_t got, input char_t exp);
		if (got !== exp)
			stop_on_error($sformatf("Fail display_mem[%0d]: got %h expected %h", pos, got, exp));
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			stop_on_error($sformatf("Fail %s: got %h expected %h", name, got, exp));
	endtask

	task automatic compose_expected(input game_t g, input emote_t local_e,
		input emote_t remote_e, input int count);
		for (int p = 0; p < 16; p++)
			exp_chars[p] = glyph_none; // blanks by default
		exp_chars[5] = digit_char(count / 1000);
		exp_chars[6] = digit_char(count / 100);
		exp_chars[8] = emote_char(local_e); // our emote
		exp_chars[9] = digit_char(count / 10);
		exp_chars[10] = digit_char(count);
		exp_chars[11] = emote_char(remote_e); // their emote
		if (g <= 3'd5)
			for (int c = 0; c < 4; c++)
				exp_chars[12 + c] = game_title[g][c];
	endtask

	// display is current once cyc stays low for a few cycles
	task automatic wait_display_idle();
		int low_run;
		int waited;
		low_run = 0;
		waited = 0;
		while (low_run < 4)
		begin
			@(negedge clk);
			waited++;
			low_run = wb_out.cyc ? 0 : low_run + 1;
			if (waited > settle_timeout)
				stop_on_error("timeout: the display writer never went idle");
		end
	endtask

	////////////////////////////////////////
	// wishbone slave model
	////////////////////////////////////////
	always @(posedge clk)
	begin
		if (!rst_n)
		begin
			wb_in.ack <= 1'b0;
			busy = 1'b0;
			for (int i = 0; i < 16; i++)
				display_mem[i] <= char_t'(8'hE0 + i); // address pattern before first sweep
		end
		else if (wb_in.ack)
			wb_in.ack <= 1'b0; // ack lasts one cycle
		else if (wb_out.cyc && wb_out.stb)
		begin
			if (!wb_out.we)
				stop_on_error("write enable was low during a display strobe");
			if (!busy)
			begin
				busy = 1'b1;
				req_adr = wb_out.adr;
				req_dat = wb_out.dat;
				for (int b = 0; b < 2; b++)
				begin
					ack_wait[b] = lfsr[0]; // one lfsr step per bit
					lfsr = lfsr_step(lfsr);
				end
			end
			else if (wb_out.adr != req_adr || wb_out.dat != req_dat)
				stop_on_error("adr or dat changed while the slave held back ack");
			if (ack_wait == 2'd0)
			begin
				wb_in.ack <= 1'b1;
				display_mem[wb_out.adr] <= wb_out.dat; // write lands
				busy = 1'b0;
			end
			else
				ack_wait = ack_wait - 2'd1;
		end
	end

	////////////////////////////////////////
	// stimulus and checks
	////////////////////////////////////////
	initial
	begin
		row_t r;
		int exp_count;
		logic exp_valid;
		key_t exp_key;
		emote_t exp_emote;
		exp_count = count_start;
		exp_valid = 1'b0;
		exp_key = '0;
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;
		for (int i = 0; i < n_rows; i++)
		begin
			r = stim[i];
			@(posedge clk);
			phase <= r.phase;
			game <= r.game;
			key <= r.key;
			pressed <= r.pressed;
			emote_in <= r.emote_in;
			repeat (int'(r.ticks) * tick_div) @(posedge clk);
			wait_display_idle();
			// debounce model with sync and up to deb_len+1 ticks
			if (r.pressed && int'(r.ticks) >= deb_len + 2 && !exp_valid)
			begin
				exp_valid = 1'b1;
				exp_key = r.key;
			end
			else if (!r.pressed && int'(r.ticks) >= deb_len + 2)
				exp_valid = 1'b0;
			if (r.phase == phase_idle)
				exp_count = count_start; // reload
			else if (r.phase == phase_countdown)
				exp_count = (int'(r.ticks) >= exp_count) ? 0 : exp_count - int'(r.ticks);
			exp_emote = exp_valid ? key_emote[exp_key] : emote_none;
			compose_expected(r.game, exp_emote, r.emote_in, exp_count);
			for (int p = 0; p < 16; p++)
				check_char(pos_t'(p), display_mem[p], exp_chars[p]);
			check_emote("emote_out", emote_out, exp_emote);
			check_bit("count_done", count_done, exp_count == 0 && r.phase != phase_idle);
		end
		$display("PASS: all tests");
		$finish;
	end

endmodule

/* screen_top.sv */
`timescale 1ns/10ps
module screen_top
	import screen_pkg::*;
#(
	parameter int TICK_DIV = 500000, // clk cycles per tick
	parameter int DEB_LEN = 4, // debounce depth in ticks
	parameter int COUNT_START = 60 // countdown start
)(
	input logic clk, // global clock
	input logic rst_n, // sync reset
	input phase_t phase, // game phase
	input game_t game, // selected game
	input key_t key, // keypad value
	input logic pressed, // keypad strobe
	input emote_t emote_in, // from other board
	input wb_s2m_t wb_in, // display reply
	output emote_t emote_out, // to other board
	output logic count_done, // countdown at zero
	output wb_m2s_t wb_out // display request
);

	logic tick; // slow step
	logic key_valid; // debounced press
	key_t key_held; // latched key
	digit_t [3:0] digits; // countdown value
	screen_t line; // composed line

	key_input #(.TICK_DIV(TICK_DIV), .DEB_LEN(DEB_LEN)) i_key_input (
		.clk(clk), .rst_n(rst_n), .key(key), .pressed(pressed),
		.tick(tick), .key_valid(key_valid), .key_held(key_held)
	);

	count_down #(.COUNT_START(COUNT_START)) i_count_down (
		.clk(clk), .rst_n(rst_n), .tick(tick), .phase(phase),
		.digits(digits), .count_done(count_done)
	);

	count_down_screen i_count_down_screen (
		.clk(clk), .rst_n(rst_n), .game(game), .digits(digits),
		.key_valid(key_valid), .key_held(key_held), .emote_in(emote_in),
		.line(line), .emote_out(emote_out)
	);

	screen_wb_writer i_screen_wb_writer (
		.clk(clk), .rst_n(rst_n), .line(line), .wb_in(wb_in), .wb_out(wb_out)
	);

endmodule

/* screen_wb_writer.sv */
`timescale 1ns/10ps
module screen_wb_writer
	import screen_pkg::*;
(
	input logic clk, // global clock
	input logic rst_n, // sync reset
	input screen_t line, // line to show
	input wb_s2m_t wb_in, // display slave reply
	output wb_m2s_t wb_out // display master request
);

	typedef enum logic [1:0] {
		st_idle, // display matches snapshot
		st_write, // strobe one char
		st_gap, // stb low between chars
		st_done // drop cyc after the sweep
	} wr_state_t;

	wr_state_t state; // writer fsm
	screen_t snap; // line being written
	pos_t pos; // current char
	logic synced; // a first sweep has run
	logic sweep_start; // new line to copy

	assign sweep_start = (state == st_idle) && (!synced || line != snap);

	////////////////////////////////////////
	// sweep fsm
	////////////////////////////////////////
	always_ff @(posedge clk)
		if (!rst_n)
		begin
			state <= st_idle;
			pos <= '0;
			synced <= 1'b0; // force one sweep after reset
		end
		else
			case (state)
				st_idle:
					if (sweep_start)
					begin
						pos <= '0;
						synced <= 1'b1;
						state <= st_write;
					end
				st_write:
					if (wb_in.ack) // late ack just holds the bus
					begin
						if (pos == 4'd15)
							state <= st_done; // last char taken
						else
						begin
							pos <= pos + 4'd1;
							state <= st_gap;
						end
					end
				st_gap: state <= st_write; // one idle strobe cycle
				default: state <= st_idle; // cyc low for a cycle
			endcase

	always_ff @(posedge clk)
		if (sweep_start)
			snap <= line; // later changes wait for the next sweep

	always_comb
	begin
		wb_out.cyc = (state == st_write) || (state == st_gap); // whole sweep
		wb_out.stb = (state == st_write);
		wb_out.we = 1'b1;
		wb_out.adr = pos;
		wb_out.dat = snap.ch[pos];
	end

	// request held until the slave answers
	a_wb_hold: assert property (@(posedge clk) disable iff (!rst_n)
		wb_out.stb && !wb_in.ack |=> wb_out.stb && $stable(wb_out.adr) && $stable(wb_out.dat));

endmodule

/* count_down_screen.sv */
`timescale 1ns/10ps
module count_down_screen
	import screen_pkg::*;
(
	input logic clk, // global clock
	input logic rst_n, // sync reset
	input game_t game, // selected game
	input digit_t [3:0] digits, // countdown value
	input logic key_valid, // debounced press
	input key_t key_held, // pressed key
	input emote_t emote_in, // emote from other board
	output screen_t line, // composed line
	output emote_t emote_out // emote to other board
);

	emote_t local_emote; // emote of local key
	title_t title; // title chars or blanks
	screen_t line_next; // line before the register

	////////////////////////////////////////
	// code to glyph maps
	////////////////////////////////////////
	function automatic char_t emote_glyph(emote_t e);
		case (e)
			4'd0: emote_glyph = glyph_smile;
			4'd1: emote_glyph = glyph_angry;
			4'd2: emote_glyph = glyph_sleepy;
			4'd3: emote_glyph = glyph_shine;
			4'd4: emote_glyph = glyph_love;
			4'd5: emote_glyph = glyph_sad;
			4'd6: emote_glyph = glyph_like;
			4'd7: emote_glyph = glyph_wave;
			default: emote_glyph = glyph_none; // 8 and up show nothing
		endcase
	endfunction

	function automatic char_t digit_glyph(digit_t d);
		digit_glyph = glyph_digit_base + char_t'(d); // ascii digit
	endfunction

	////////////////////////////////////////
	// line compose
	////////////////////////////////////////
	always_comb
	begin
		if (key_valid)
			local_emote = key_emote[key_held]; // table lookup
		else
			local_emote = emote_none; // no press

		if (game <= 3'd5)
			title = game_title[game];
		else
			title = {4{glyph_none}}; // unknown game

		line_next.ch = {
			{5{glyph_none}}, // left margin
			digit_glyph(digits[3]),
			digit_glyph(digits[2]),
			glyph_none, // gap
			emote_glyph(local_emote), // our emote
			digit_glyph(digits[1]),
			digit_glyph(digits[0]),
			emote_glyph(emote_in), // their emote
			title // right four chars
		};
	end

	always_ff @(posedge clk)
		if (!rst_n)
		begin
			line <= screen_blank;
			emote_out <= emote_none;
		end
		else
		begin
			line <= line_next;
			emote_out <= local_emote;
		end

endmodule

/* count_down.sv */
`timescale 1ns/10ps
module count_down
	import screen_pkg::*;
#(
	parameter int COUNT_START = 60 // decimal start value 0..9999
)(
	input logic clk, // global clock
	input logic rst_n, // sync reset
	input logic tick, // step enable
	input phase_t phase, // game phase from outside fsm
	output digit_t [3:0] digits, // digits[3] is thousands
	output logic count_done // reached zero
);

	// start value split into bcd
	localparam digit_t [3:0] start_digits = {
		digit_t'((COUNT_START / 1000) % 10),
		digit_t'((COUNT_START / 100) % 10),
		digit_t'((COUNT_START / 10) % 10),
		digit_t'(COUNT_START % 10)
	};

	digit_t [3:0] digits_dec; // value minus one
	logic borrow; // ripple between digits
	logic is_zero; // all digits zero

	always_comb
	begin
		borrow = 1'b1; // take one off the units
		for (int i = 0; i < 4; i++)
		begin
			if (borrow && digits[i] == 4'd0)
				digits_dec[i] = 4'd9; // wrap and keep borrowing
			else if (borrow)
			begin
				digits_dec[i] = digits[i] - 4'd1;
				borrow = 1'b0; // borrow absorbed
			end
			else
				digits_dec[i] = digits[i];
		end
	end

	assign is_zero = (digits == '0);
	assign count_done = is_zero && (phase != phase_idle);

	always_ff @(posedge clk)
		if (!rst_n)
			digits <= start_digits;
		else
			case (phase)
				phase_idle: digits <= start_digits; // reload
				phase_countdown:
					if (tick && !is_zero)
						digits <= digits_dec; // step and saturate at zero
				default: digits <= digits; // play holds
			endcase

	// borrow ripple must keep every digit decimal
	a_digits_bcd: assert property (@(posedge clk) disable iff (!rst_n)
		digits[3] <= 4'd9 && digits[2] <= 4'd9 && digits[1] <= 4'd9 && digits[0] <= 4'd9);

endmodule

/* key_input.sv */
`timescale 1ns/10ps
module key_input
	import screen_pkg::*;
#(
	parameter int TICK_DIV = 500000, // clk cycles per tick
	parameter int DEB_LEN = 4 // ticks a level must hold
)(
	input logic clk, // global clock
	input logic rst_n, // sync reset
	input key_t key, // scanned key value
	input logic pressed, // raw press strobe
	output logic tick, // one clk pulse per period
	output logic key_valid, // debounced press
	output key_t key_held // key latched at press
);

	localparam int div_w = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

	logic [div_w-1:0] div_cnt; // prescaler count
	logic [1:0] sync_q; // pressed synchronizer
	logic [DEB_LEN-1:0] hist; // tick sampled history
	logic [DEB_LEN-1:0] hist_next; // history with this sample
	logic press_rise; // press becomes valid

	////////////////////////////////////////
	// tick prescaler
	////////////////////////////////////////
	always_ff @(posedge clk)
		if (!rst_n)
		begin
			div_cnt <= '0;
			tick <= 1'b0;
		end
		else if (div_cnt == div_w'(TICK_DIV - 1))
		begin
			div_cnt <= '0; // wrap
			tick <= 1'b1; // one pulse
		end
		else
		begin
			div_cnt <= div_cnt + 1'b1;
			tick <= 1'b0;
		end

	////////////////////////////////////////
	// debounce
	////////////////////////////////////////
	assign hist_next = DEB_LEN'({hist, sync_q[1]}); // newest sample at bit 0
	assign press_rise = tick && (&hist_next) && !key_valid; // all ones and was released

	always_ff @(posedge clk)
		if (!rst_n)
		begin
			sync_q <= 2'b00;
			hist <= '0;
			key_valid <= 1'b0;
		end
		else
		begin
			sync_q <= {sync_q[0], pressed}; // two flop sync
			if (tick)
			begin
				hist <= hist_next;
				if (press_rise)
					key_valid <= 1'b1; // held long enough
				else if (~|hist_next)
					key_valid <= 1'b0; // released long enough
			end
		end

	always_ff @(posedge clk)
		if (press_rise)
			key_held <= key; // keep key of this press

	// prescaler must leave a gap between ticks
	a_tick_single: assert property (@(posedge clk) disable iff (!rst_n) tick |=> !tick);

endmodule

/* screen_pkg.sv */
package screen_pkg;

	////////////////////////////////////////
	// widths with a meaning
	////////////////////////////////////////
	typedef logic [7:0] char_t; // one display character
	typedef logic [3:0] key_t; // keypad hex digit
	typedef logic [3:0] emote_t; // 0..7 emotes and 8 none
	typedef logic [2:0] game_t; // 0..5 games
	typedef logic [3:0] digit_t; // one bcd digit
	typedef logic [3:0] pos_t; // display address

	typedef char_t [0:3] title_t; // four chars of a game title

	typedef struct packed {
		char_t [0:15] ch; // ch[0] is the left char
	} screen_t;

	typedef enum logic [1:0] {
		phase_idle = 2'd0, // waiting for a game
		phase_countdown = 2'd1, // counting to start
		phase_play = 2'd2 // game running
	} phase_t;

	////////////////////////////////////////
	// wishbone display port
	////////////////////////////////////////
	typedef struct packed {
		logic cyc; // bus cycle
		logic stb; // strobe
		logic we; // always write
		pos_t adr; // char position
		char_t dat; // char code
	} wb_m2s_t;

	typedef struct packed {
		logic ack; // slave done
	} wb_s2m_t;

	////////////////////////////////////////
	// glyphs and tables
	////////////////////////////////////////
	localparam char_t glyph_none = 8'h20; // space
	localparam char_t glyph_digit_base = 8'h30; // ascii zero
	localparam char_t glyph_smile = 8'h80;
	localparam char_t glyph_angry = 8'h81;
	localparam char_t glyph_sleepy = 8'h82;
	localparam char_t glyph_shine = 8'h83;
	localparam char_t glyph_love = 8'h84;
	localparam char_t glyph_sad = 8'h85;
	localparam char_t glyph_like = 8'h86;
	localparam char_t glyph_wave = 8'h87;

	localparam emote_t emote_none = 4'd8; // no emote sent

	localparam screen_t screen_blank = '{ch: {16{glyph_none}}}; // all spaces

	// key to emote, indexed by key value 0..F
	localparam emote_t key_emote [0:15] = '{
		4'd4, 4'd5, 4'd1, 4'd8, // keys 0 1 2 3
		4'd6, 4'd2, 4'd8, 4'd7, // keys 4 5 6 7
		4'd3, 4'd8, 4'd0, 4'd8, // keys 8 9 A B
		4'd8, 4'd8, 4'd8, 4'd8 // keys C D E F
	};

	localparam title_t game_title [0:5] = '{"FLIK", "TNUM", "FOLW", "UNFO", "HILO", "RAIN"};

endpackage
